//--- sources.f
+incdir+logic
logic/mem_port_pkg.sv
logic/axi_mst_if.sv
logic/write_buffer.sv
logic/line_fill.sv
logic/axi_arbiter.sv
logic/dcache_mem_port.sv
bench/clock_gen.sv
bench/tb_dcache_mem_port.sv

//--- run_sim.sh
#!/bin/bash
# build and run the dcache memory port testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_dcache_mem_port -o tb_dcache_mem_port \
    && ./obj_dir/tb_dcache_mem_port | tee sim.log \
    && grep -q "ALL TESTS PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- bench/tb_dcache_mem_port.sv
`timescale 1ns/10ps
`include "mem_port_defines.svh"

module tb_dcache_mem_port;

    localparam int CLK_NS     = 8;
    localparam int RAND_OPS   = 60;
    localparam int TXN_COUNT  = 12 + RAND_OPS;
    localparam int TIMEOUT_NS = 200 * TXN_COUNT * CLK_NS;

    logic clock;
    logic reset;

    logic                      wr_req_i;
    logic [`ADDR_W-1:0]        wr_addr_i;
    mem_port_pkg::line_u       wr_line_i;
    logic [3:0]                wr_strb_i;
    mem_port_pkg::store_type_e wr_type_i;
    logic                      wr_rdy_o;
    logic                      fill_req_i;
    logic [`ADDR_W-1:0]        fill_addr_i;
    logic                      fill_rdy_o;
    logic                      fill_valid_o;
    mem_port_pkg::line_u       fill_line_o;
    logic [`ADDR_W-1:0]        m_aw_addr_o;
    logic [7:0]                m_aw_len_o;
    logic [2:0]                m_aw_size_o;
    logic                      m_aw_valid_o;
    logic                      m_aw_ready_i;
    logic [31:0]               m_w_data_o;
    logic [3:0]                m_w_strb_o;
    logic                      m_w_last_o;
    logic                      m_w_valid_o;
    logic                      m_w_ready_i;
    logic                      m_b_valid_i;
    logic                      m_b_ready_o;
    logic [`ADDR_W-1:0]        m_ar_addr_o;
    logic [7:0]                m_ar_len_o;
    logic [2:0]                m_ar_size_o;
    logic                      m_ar_valid_o;
    logic                      m_ar_ready_i;
    logic [31:0]               m_r_data_i;
    logic                      m_r_last_i;
    logic                      m_r_valid_i;
    logic                      m_r_ready_o;

    integer seed = 32'h6da9898f;
    int     mismatch_cnt;
    int     protocol_cnt;
    int     check_cnt;
    int     cycle_cnt;
    int     aw_stamp;
    int     ar_stamp;

    logic [31:0] mem [0:255];     // responder memory
    logic [31:0] model [0:255];   // reference copy
    mem_port_pkg::line_u exp_q [$];

    // responder and monitor state
    logic [7:0]  wr_idx, wr_len, wr_beat;
    logic [7:0]  rd_idx, rd_len, rd_beat, r_shown;
    logic        b_pend, rd_open, stall_en;
    logic        aw_wait, w_wait, ar_wait;
    logic [43:0] aw_prev, ar_prev;
    logic [37:0] w_prev;
    logic [7:0]  last_aw_len, w_beats;
    logic [2:0]  last_aw_size;
    logic [3:0]  last_w_strb;

    clock_gen #(.PERIOD_NS(CLK_NS), .RESET_CYCLES(2)) clock_gen_inst (
        .clock_o (clock),
        .reset_o (reset)
    );

    dcache_mem_port dcache_mem_port_inst (.*);

    function automatic logic [31:0] fill_word(input logic [7:0] i);
        return {i ^ 8'h3c, ~i, i + 8'h11, i};
    endfunction

    function automatic logic coin();
        if (!stall_en) return 1'b1;
        return ($random(seed) & 32'h3) != 0;   // ready 3 times in 4
    endfunction

    // byte-lane merge of one store into the reference memory
    function automatic void merge_store(input logic [31:0] addr, input mem_port_pkg::line_u data,
                                        input logic [3:0] strb,
                                        input mem_port_pkg::store_type_e kind);
        logic [7:0] idx;
        int b;
        idx = addr[9:2];
        if (kind == mem_port_pkg::st_line) begin
            idx = {addr[9:4], 2'b00};   // bursts start on the line
            for (b = 0; b < `LINE_BEATS; b++) model[idx + 8'(b)] = data.words[b];
        end else begin
            for (b = 0; b < 4; b++) begin
                if (strb[b]) model[idx][b*8 +: 8] = data.words[0][b*8 +: 8];
            end
        end
    endfunction

    function automatic mem_port_pkg::line_u expected_line(input logic [31:0] addr);
        mem_port_pkg::line_u ln;
        logic [7:0] base;
        int b;
        base = {addr[9:4], 2'b00};
        for (b = 0; b < `LINE_BEATS; b++) ln.words[b] = model[base + 8'(b)];
        return ln;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        check_cnt++;
        if (expected !== actual) begin
            mismatch_cnt++;
            $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic report_protocol(input string msg);
        protocol_cnt++;
        $display("%0t: protocol error, %s", $time, msg);
    endtask

    task automatic do_store(input logic [31:0] addr, input mem_port_pkg::line_u data,
                            input logic [3:0] strb, input mem_port_pkg::store_type_e kind);
        while (!wr_rdy_o) @(negedge clock);
        wr_addr_i = addr;
        wr_line_i = data;
        wr_strb_i = strb;
        wr_type_i = kind;
        wr_req_i  = 1'b1;
        merge_store(addr, data, strb, kind);
        @(negedge clock);
        wr_req_i = 1'b0;
    endtask

    task automatic do_fill(input logic [31:0] addr);
        while (!fill_rdy_o) @(negedge clock);
        fill_addr_i = addr;
        fill_req_i  = 1'b1;
        exp_q.push_back(expected_line(addr));
        @(negedge clock);
        fill_req_i = 1'b0;
    endtask

    // both requests in the same cycle, store merged first
    task automatic store_and_fill(input logic [31:0] addr, input mem_port_pkg::line_u data);
        while (!(wr_rdy_o && fill_rdy_o)) @(negedge clock);
        wr_addr_i   = addr;
        wr_line_i   = data;
        wr_strb_i   = 4'hf;
        wr_type_i   = mem_port_pkg::st_word;
        wr_req_i    = 1'b1;
        fill_addr_i = addr;
        fill_req_i  = 1'b1;
        merge_store(addr, data, 4'hf, mem_port_pkg::st_word);
        exp_q.push_back(expected_line(addr));
        @(negedge clock);
        wr_req_i   = 1'b0;
        fill_req_i = 1'b0;
    endtask

    task automatic wait_idle();
        while (!(wr_rdy_o && fill_rdy_o && exp_q.size() == 0)) @(negedge clock);
    endtask

    task automatic check_store_shape(input logic [7:0] len, input logic [2:0] size,
                                     input logic [3:0] strb, input logic [7:0] beats);
        wait_idle();
        check_value("m_aw_len_o", len, last_aw_len);
        check_value("m_aw_size_o", size, last_aw_size);
        check_value("m_w_strb_o", strb, last_w_strb);
        check_value("W beat count", beats, w_beats);
    endtask

    // handshakes as seen at the rising edge
    always @(posedge clock) begin : bus_monitor
        logic [7:0] widx;
        int k;
        cycle_cnt++;
        if (reset) begin
            b_pend  = 1'b0;
            rd_open = 1'b0;
            aw_wait = 1'b0;
            w_wait  = 1'b0;
            ar_wait = 1'b0;
        end else begin
            if (aw_wait && aw_prev != {m_aw_valid_o, m_aw_addr_o, m_aw_len_o, m_aw_size_o})
                report_protocol("AW payload changed or valid dropped before its handshake");
            if (w_wait && w_prev != {m_w_valid_o, m_w_data_o, m_w_strb_o, m_w_last_o})
                report_protocol("W payload changed or valid dropped before its handshake");
            if (ar_wait && ar_prev != {m_ar_valid_o, m_ar_addr_o, m_ar_len_o, m_ar_size_o})
                report_protocol("AR payload changed or valid dropped before its handshake");
            aw_wait = m_aw_valid_o && !m_aw_ready_i;
            w_wait  = m_w_valid_o && !m_w_ready_i;
            ar_wait = m_ar_valid_o && !m_ar_ready_i;
            aw_prev = {m_aw_valid_o, m_aw_addr_o, m_aw_len_o, m_aw_size_o};
            w_prev  = {m_w_valid_o, m_w_data_o, m_w_strb_o, m_w_last_o};
            ar_prev = {m_ar_valid_o, m_ar_addr_o, m_ar_len_o, m_ar_size_o};

            if (m_aw_valid_o && m_aw_ready_i) begin
                wr_idx       = m_aw_addr_o[9:2];
                wr_len       = m_aw_len_o;
                wr_beat      = 8'd0;
                w_beats      = 8'd0;
                last_aw_len  = m_aw_len_o;
                last_aw_size = m_aw_size_o;
                aw_stamp     = cycle_cnt;
            end
            if (m_w_valid_o && m_w_ready_i) begin
                widx = wr_idx + wr_beat;   // incrementing burst
                for (k = 0; k < 4; k++) begin
                    if (m_w_strb_o[k]) mem[widx][k*8 +: 8] = m_w_data_o[k*8 +: 8];
                end
                if (m_w_last_o != (wr_beat == wr_len))
                    report_protocol("W last flag does not match the burst length");
                last_w_strb = m_w_strb_o;
                wr_beat++;
                w_beats = wr_beat;
                if (m_w_last_o) b_pend = 1'b1;
            end
            if (m_b_valid_i && m_b_ready_o) b_pend = 1'b0;
            if (m_ar_valid_o && m_ar_ready_i) begin
                if (m_ar_len_o != 8'(`LINE_BEATS - 1) || m_ar_size_o != `AXI_SIZE_4)
                    report_protocol("AR burst is not one full line of words");
                rd_idx   = m_ar_addr_o[9:2];
                rd_len   = m_ar_len_o;
                rd_beat  = 8'd0;
                rd_open  = 1'b1;
                ar_stamp = cycle_cnt;
            end
            if (m_r_valid_i && m_r_ready_o) begin
                if (m_r_last_i) rd_open = 1'b0;
                rd_beat++;
            end
        end
    end

    // slave side driven on the falling edge
    always @(negedge clock) begin
        if (reset) begin
            m_aw_ready_i = 1'b0;
            m_w_ready_i  = 1'b0;
            m_ar_ready_i = 1'b0;
            m_b_valid_i  = 1'b0;
            m_r_valid_i  = 1'b0;
        end else begin
            m_aw_ready_i = coin();
            m_w_ready_i  = coin();
            m_ar_ready_i = coin();
            if (!b_pend) m_b_valid_i = 1'b0;
            else if (!m_b_valid_i) m_b_valid_i = coin();
            if (!rd_open) begin
                m_r_valid_i = 1'b0;
            end else if (!m_r_valid_i || r_shown != rd_beat) begin
                r_shown     = rd_beat;   // held until it fires
                m_r_data_i  = mem[rd_idx + rd_beat];
                m_r_last_i  = (rd_beat == rd_len);
                m_r_valid_i = coin();
            end
        end
    end

    always @(posedge clock) begin : fill_compare
        if (!reset && fill_valid_o) begin
            if (exp_q.size() == 0) report_protocol("fill_valid_o pulsed with no fill pending");
            else check_value("fill_line_o", exp_q.pop_front(), fill_line_o.flat);
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        mem_port_pkg::line_u data;
        logic [31:0] r;
        logic [31:0] addr;
        int i;
        wr_req_i     = 1'b0;
        wr_addr_i    = '0;
        wr_line_i    = '0;
        wr_strb_i    = 4'h0;
        wr_type_i    = mem_port_pkg::st_word;
        fill_req_i   = 1'b0;
        fill_addr_i  = '0;
        m_aw_ready_i = 1'b0;
        m_w_ready_i  = 1'b0;
        m_b_valid_i  = 1'b0;
        m_ar_ready_i = 1'b0;
        m_r_data_i   = '0;
        m_r_last_i   = 1'b0;
        m_r_valid_i  = 1'b0;
        stall_en     = 1'b0;
        r_shown      = 8'd0;
        for (i = 0; i < 256; i++) begin
            mem[i]   = fill_word(8'(i));
            model[i] = fill_word(8'(i));
        end
        @(negedge clock);
        while (reset) @(negedge clock);

        check_value("{aw,w,ar,fill}_valid", 4'b0000,
                    {m_aw_valid_o, m_w_valid_o, m_ar_valid_o, fill_valid_o});
        check_value("{wr_rdy_o,fill_rdy_o}", 2'b11, {wr_rdy_o, fill_rdy_o});

        // single stores of each width, then read back
        data = '0;
        data.words[0] = 32'hcafe_f00d;
        do_store(32'h100, data, 4'hf, mem_port_pkg::st_word);
        check_store_shape(8'd0, `AXI_SIZE_4, 4'hf, 8'd1);
        data.words[0] = 32'h1234_5678;
        do_store(32'h106, data, 4'b1100, mem_port_pkg::st_half);
        check_store_shape(8'd0, `AXI_SIZE_2, 4'b1100, 8'd1);
        data.words[0] = 32'h0000_a500;
        do_store(32'h109, data, 4'b0010, mem_port_pkg::st_byte);
        check_store_shape(8'd0, `AXI_SIZE_1, 4'b0010, 8'd1);
        do_fill(32'h100);
        wait_idle();

        data.words = {32'h4444_4444, 32'h3333_3333, 32'h2222_2222, 32'h1111_1111};
        do_store(32'h48, data, 4'hf, mem_port_pkg::st_line);   // unaligned on purpose
        check_store_shape(8'(`LINE_BEATS - 1), `AXI_SIZE_4, 4'hf, 8'(`LINE_BEATS));
        do_fill(32'h4c);
        wait_idle();

        data.words[0] = 32'hdead_beef;
        store_and_fill(32'h208, data);
        wait_idle();
        if (ar_stamp <= aw_stamp) report_protocol("fill read went out before the pending write");

        // random traffic with stalls on every channel
        stall_en = 1'b1;
        for (i = 0; i < RAND_OPS; i++) begin
            r = $random(seed);
            addr = {22'd0, r[9:0]};
            data.words[0] = $random(seed);
            data.words[1] = $random(seed);
            data.words[2] = $random(seed);
            data.words[3] = $random(seed);
            case (r[12:10])
                3'd1: do_store(addr, data, 4'b0001 << addr[1:0], mem_port_pkg::st_byte);
                3'd2: do_store({addr[31:1], 1'b0}, data, addr[1] ? 4'b1100 : 4'b0011,
                               mem_port_pkg::st_half);
                3'd3: do_store({addr[31:2], 2'b00}, data, 4'hf, mem_port_pkg::st_word);
                3'd4: do_store(addr, data, 4'hf, mem_port_pkg::st_line);
                default: do_fill(addr);
            endcase
        end
        do_fill(32'h000);
        do_fill(32'h100);
        do_fill(32'h200);
        do_fill(32'h3f0);
        wait_idle();

        $display("checks: %0d  mismatches: %0d  protocol errors: %0d",
                 check_cnt, mismatch_cnt, protocol_cnt);
        if (mismatch_cnt == 0 && protocol_cnt == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- bench/clock_gen.sv
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 2
) (
    output logic clock_o,
    output logic reset_o
);
    initial begin
        clock_o = 1'b0;
        forever #(PERIOD_NS / 2) clock_o = ~clock_o;
    end

    // reset seen high on the first RESET_CYCLES rising edges
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock_o);
        reset_o <= 1'b0;
    end

endmodule

//--- logic/dcache_mem_port.sv
`timescale 1ns/10ps
`include "mem_port_defines.svh"

module dcache_mem_port (
    input  logic                      clock,
    input  logic                      reset,
    // cache store side
    input  logic                      wr_req_i,
    input  logic [`ADDR_W-1:0]        wr_addr_i,
    input  mem_port_pkg::line_u       wr_line_i,
    input  logic [3:0]                wr_strb_i,
    input  mem_port_pkg::store_type_e wr_type_i,
    output logic                      wr_rdy_o,
    // cache refill side
    input  logic                      fill_req_i,
    input  logic [`ADDR_W-1:0]        fill_addr_i,
    output logic                      fill_rdy_o,
    output logic                      fill_valid_o,
    output mem_port_pkg::line_u       fill_line_o,
    // AXI4 master
    output logic [`ADDR_W-1:0]        m_aw_addr_o,
    output logic [7:0]                m_aw_len_o,
    output logic [2:0]                m_aw_size_o,
    output logic                      m_aw_valid_o,
    input  logic                      m_aw_ready_i,
    output logic [31:0]               m_w_data_o,
    output logic [3:0]                m_w_strb_o,
    output logic                      m_w_last_o,
    output logic                      m_w_valid_o,
    input  logic                      m_w_ready_i,
    input  logic                      m_b_valid_i,
    output logic                      m_b_ready_o,
    output logic [`ADDR_W-1:0]        m_ar_addr_o,
    output logic [7:0]                m_ar_len_o,
    output logic [2:0]                m_ar_size_o,
    output logic                      m_ar_valid_o,
    input  logic                      m_ar_ready_i,
    input  logic [31:0]               m_r_data_i,
    input  logic                      m_r_last_i,
    input  logic                      m_r_valid_i,
    output logic                      m_r_ready_o
);
    axi_mst_if wb_bus ();
    axi_mst_if lf_bus ();
    axi_mst_if mem_bus ();

    write_buffer write_buffer_inst (
        .clock     (clock),
        .reset     (reset),
        .wr_req_i  (wr_req_i),
        .wr_addr_i (wr_addr_i),
        .wr_line_i (wr_line_i),
        .wr_strb_i (wr_strb_i),
        .wr_type_i (wr_type_i),
        .wr_rdy_o  (wr_rdy_o),
        .bus       (wb_bus.master)
    );

    line_fill line_fill_inst (
        .clock        (clock),
        .reset        (reset),
        .fill_req_i   (fill_req_i),
        .fill_addr_i  (fill_addr_i),
        .fill_rdy_o   (fill_rdy_o),
        .fill_valid_o (fill_valid_o),
        .fill_line_o  (fill_line_o),
        .bus          (lf_bus.master)
    );

    axi_arbiter axi_arbiter_inst (
        .clock   (clock),
        .reset   (reset),
        .wb_bus  (wb_bus.slave),
        .lf_bus  (lf_bus.slave),
        .mem_bus (mem_bus.master)
    );

    // arbiter's downstream port onto the pins
    assign m_aw_addr_o      = mem_bus.aw_addr;
    assign m_aw_len_o       = mem_bus.aw_len;
    assign m_aw_size_o      = mem_bus.aw_size;
    assign m_aw_valid_o     = mem_bus.aw_valid;
    assign mem_bus.aw_ready = m_aw_ready_i;
    assign m_w_data_o       = mem_bus.w_data;
    assign m_w_strb_o       = mem_bus.w_strb;
    assign m_w_last_o       = mem_bus.w_last;
    assign m_w_valid_o      = mem_bus.w_valid;
    assign mem_bus.w_ready  = m_w_ready_i;
    assign mem_bus.b_valid  = m_b_valid_i;
    assign m_b_ready_o      = mem_bus.b_ready;
    assign m_ar_addr_o      = mem_bus.ar_addr;
    assign m_ar_len_o       = mem_bus.ar_len;
    assign m_ar_size_o      = mem_bus.ar_size;
    assign m_ar_valid_o     = mem_bus.ar_valid;
    assign mem_bus.ar_ready = m_ar_ready_i;
    assign mem_bus.r_data   = m_r_data_i;
    assign mem_bus.r_last   = m_r_last_i;
    assign mem_bus.r_valid  = m_r_valid_i;
    assign m_r_ready_o      = mem_bus.r_ready;

endmodule

//--- logic/axi_arbiter.sv
`timescale 1ns/10ps

module axi_arbiter (
    input  logic      clock,
    input  logic      reset,
    axi_mst_if.slave  wb_bus,
    axi_mst_if.slave  lf_bus,
    axi_mst_if.master mem_bus
);
    typedef enum logic [1:0] {OWN_NONE, OWN_WR, OWN_RD} owner_e;

    owner_e owner_q;
    owner_e owner;     // effective owner this cycle
    logic   gnt_wr;
    logic   gnt_rd;

    // writes first so a fill sees every earlier store
    always_comb begin
        owner = owner_q;
        if (owner_q == OWN_NONE) begin
            if (wb_bus.aw_valid) owner = OWN_WR;
            else if (lf_bus.ar_valid) owner = OWN_RD;
        end
    end

    assign gnt_wr = (owner == OWN_WR);
    assign gnt_rd = (owner == OWN_RD);

    always_ff @(posedge clock) begin
        if (reset) begin
            owner_q <= OWN_NONE;
        end else if (owner_q == OWN_NONE) begin
            owner_q <= owner;   // lock once a request is shown
        end else if (owner_q == OWN_WR && mem_bus.b_valid && mem_bus.b_ready) begin
            owner_q <= OWN_NONE;
        end else if (owner_q == OWN_RD && mem_bus.r_valid && mem_bus.r_ready
                     && mem_bus.r_last) begin
            owner_q <= OWN_NONE;
        end
    end

    // owner's request channels out to memory
    assign mem_bus.aw_addr  = gnt_wr ? wb_bus.aw_addr : lf_bus.aw_addr;
    assign mem_bus.aw_len   = gnt_wr ? wb_bus.aw_len : lf_bus.aw_len;
    assign mem_bus.aw_size  = gnt_wr ? wb_bus.aw_size : lf_bus.aw_size;
    assign mem_bus.aw_valid = (gnt_wr && wb_bus.aw_valid) || (gnt_rd && lf_bus.aw_valid);
    assign mem_bus.w_data   = gnt_wr ? wb_bus.w_data : lf_bus.w_data;
    assign mem_bus.w_strb   = gnt_wr ? wb_bus.w_strb : lf_bus.w_strb;
    assign mem_bus.w_last   = gnt_wr ? wb_bus.w_last : lf_bus.w_last;
    assign mem_bus.w_valid  = (gnt_wr && wb_bus.w_valid) || (gnt_rd && lf_bus.w_valid);
    assign mem_bus.b_ready  = (gnt_wr && wb_bus.b_ready) || (gnt_rd && lf_bus.b_ready);
    assign mem_bus.ar_addr  = gnt_wr ? wb_bus.ar_addr : lf_bus.ar_addr;
    assign mem_bus.ar_len   = gnt_wr ? wb_bus.ar_len : lf_bus.ar_len;
    assign mem_bus.ar_size  = gnt_wr ? wb_bus.ar_size : lf_bus.ar_size;
    assign mem_bus.ar_valid = (gnt_wr && wb_bus.ar_valid) || (gnt_rd && lf_bus.ar_valid);
    assign mem_bus.r_ready  = (gnt_wr && wb_bus.r_ready) || (gnt_rd && lf_bus.r_ready);

    // responses back, non-owner sees nothing
    assign wb_bus.aw_ready = gnt_wr && mem_bus.aw_ready;
    assign wb_bus.w_ready  = gnt_wr && mem_bus.w_ready;
    assign wb_bus.b_valid  = gnt_wr && mem_bus.b_valid;
    assign wb_bus.ar_ready = gnt_wr && mem_bus.ar_ready;
    assign wb_bus.r_data   = mem_bus.r_data;
    assign wb_bus.r_last   = mem_bus.r_last;
    assign wb_bus.r_valid  = gnt_wr && mem_bus.r_valid;
    assign lf_bus.aw_ready = gnt_rd && mem_bus.aw_ready;
    assign lf_bus.w_ready  = gnt_rd && mem_bus.w_ready;
    assign lf_bus.b_valid  = gnt_rd && mem_bus.b_valid;
    assign lf_bus.ar_ready = gnt_rd && mem_bus.ar_ready;
    assign lf_bus.r_data   = mem_bus.r_data;
    assign lf_bus.r_last   = mem_bus.r_last;
    assign lf_bus.r_valid  = gnt_rd && mem_bus.r_valid;

    // a read may never overtake a write in progress
    no_read_in_write_a: assert property (@(posedge clock) disable iff (reset)
        (wb_bus.w_valid || wb_bus.b_ready) |-> !mem_bus.ar_valid);

endmodule

//--- logic/line_fill.sv
`timescale 1ns/10ps
`include "mem_port_defines.svh"

module line_fill (
    input  logic                clock,
    input  logic                reset,
    input  logic                fill_req_i,
    input  logic [`ADDR_W-1:0]  fill_addr_i,
    output logic                fill_rdy_o,
    output logic                fill_valid_o,
    output mem_port_pkg::line_u fill_line_o,
    axi_mst_if.master           bus
);
    localparam int BEAT_W = $clog2(`LINE_BEATS);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_DONE} state_e;

    state_e              state;
    logic [BEAT_W-1:0]   beat;
    logic [`ADDR_W-1:0]  addr_q;
    mem_port_pkg::line_u line_q;
    logic                accept;
    logic                r_fire;

    assign accept = fill_req_i && fill_rdy_o;
    assign r_fire = bus.r_valid && bus.r_ready;

    // line aligned request address
    always_ff @(posedge clock) begin
        if (accept) addr_q <= {fill_addr_i[`ADDR_W-1:`LINE_OFF_W], {`LINE_OFF_W{1'b0}}};
    end

    always_ff @(posedge clock) begin
        if (r_fire) line_q.words[beat] <= bus.r_data;   // one word per beat
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                S_IDLE: if (accept) begin
                    state <= S_ADDR;
                    beat  <= '0;
                end
                S_ADDR: if (bus.ar_ready) state <= S_DATA;
                S_DATA: if (r_fire) begin
                    beat <= beat + 1'b1;
                    if (bus.r_last) state <= S_DONE;
                end
                S_DONE: state <= S_IDLE;   // single cycle pulse
                default: state <= S_IDLE;
            endcase
        end
    end

    assign fill_rdy_o   = (state == S_IDLE);
    assign fill_valid_o = (state == S_DONE);
    assign fill_line_o  = line_q;

    assign bus.ar_addr  = addr_q;
    assign bus.ar_len   = 8'(`LINE_BEATS - 1);
    assign bus.ar_size  = `AXI_SIZE_4;
    assign bus.ar_valid = (state == S_ADDR);
    assign bus.r_ready  = (state == S_DATA);

    // no writes from the fill side
    assign bus.aw_addr  = '0;
    assign bus.aw_len   = '0;
    assign bus.aw_size  = '0;
    assign bus.aw_valid = 1'b0;
    assign bus.w_data   = '0;
    assign bus.w_strb   = '0;
    assign bus.w_last   = 1'b0;
    assign bus.w_valid  = 1'b0;
    assign bus.b_ready  = 1'b0;

    // memory burst length must agree with the line size
    r_last_a: assert property (@(posedge clock) disable iff (reset)
        r_fire |-> (bus.r_last == (beat == BEAT_W'(`LINE_BEATS - 1))));

endmodule

//--- logic/write_buffer.sv
`timescale 1ns/10ps
`include "mem_port_defines.svh"

module write_buffer (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      wr_req_i,
    input  logic [`ADDR_W-1:0]        wr_addr_i,
    input  mem_port_pkg::line_u       wr_line_i,
    input  logic [3:0]                wr_strb_i,
    input  mem_port_pkg::store_type_e wr_type_i,
    output logic                      wr_rdy_o,
    axi_mst_if.master                 bus
);
    localparam int BEAT_W = $clog2(`LINE_BEATS);

    typedef enum logic [1:0] {S_IDLE, S_ADDR, S_DATA, S_RESP} state_e;

    state_e                    state;
    logic [BEAT_W-1:0]         beat;
    logic [`ADDR_W-1:0]        addr_q;
    mem_port_pkg::line_u       line_q;
    logic [3:0]                strb_q;
    mem_port_pkg::store_type_e type_q;
    logic                      accept;
    logic                      is_line;
    logic                      last_beat;

    assign accept    = wr_req_i && wr_rdy_o;
    assign is_line   = (type_q == mem_port_pkg::st_line);
    assign last_beat = is_line ? (beat == BEAT_W'(`LINE_BEATS - 1)) : 1'b1;

    // the single entry
    always_ff @(posedge clock) begin
        if (accept) begin
            addr_q <= wr_addr_i;
            line_q <= wr_line_i;
            strb_q <= wr_strb_i;
            type_q <= wr_type_i;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= S_IDLE;
            beat  <= '0;
        end else begin
            case (state)
                S_IDLE: if (accept) begin
                    state <= S_ADDR;
                    beat  <= '0;
                end
                S_ADDR: if (bus.aw_ready) state <= S_DATA;
                S_DATA: if (bus.w_ready) begin
                    if (last_beat) state <= S_RESP;
                    else beat <= beat + 1'b1;   // next word of the line
                end
                S_RESP: if (bus.b_valid) state <= S_IDLE;   // resp code ignored
                default: state <= S_IDLE;
            endcase
        end
    end

    assign wr_rdy_o = (state == S_IDLE);

    // line bursts start on the line boundary
    assign bus.aw_addr  = is_line ? {addr_q[`ADDR_W-1:`LINE_OFF_W], {`LINE_OFF_W{1'b0}}}
                                  : addr_q;
    assign bus.aw_len   = is_line ? 8'(`LINE_BEATS - 1) : 8'd0;
    assign bus.aw_valid = (state == S_ADDR);

    always_comb begin
        case (type_q)
            mem_port_pkg::st_byte: bus.aw_size = `AXI_SIZE_1;
            mem_port_pkg::st_half: bus.aw_size = `AXI_SIZE_2;
            default:               bus.aw_size = `AXI_SIZE_4;
        endcase
    end

    // single stores sit in word 0 with their own lane strobe
    assign bus.w_data  = line_q.words[beat];
    assign bus.w_strb  = is_line ? 4'hf : strb_q;
    assign bus.w_last  = last_beat;
    assign bus.w_valid = (state == S_DATA);
    assign bus.b_ready = (state == S_RESP);

    // read side unused by this master
    assign bus.ar_addr  = '0;
    assign bus.ar_len   = '0;
    assign bus.ar_size  = '0;
    assign bus.ar_valid = 1'b0;
    assign bus.r_ready  = 1'b0;

    // address held steady through arbiter and memory stalls
    aw_stable_a: assert property (@(posedge clock) disable iff (reset)
        bus.aw_valid && !bus.aw_ready |=>
            bus.aw_valid && $stable(bus.aw_addr) && $stable(bus.aw_len)
            && $stable(bus.aw_size));

endmodule

//--- logic/axi_mst_if.sv
`timescale 1ns/10ps
`include "mem_port_defines.svh"

interface axi_mst_if;

    // write address
    logic [`ADDR_W-1:0] aw_addr;
    logic [7:0]         aw_len;
    logic [2:0]         aw_size;
    logic               aw_valid;
    logic               aw_ready;

    // write data
    logic [31:0]        w_data;
    logic [3:0]         w_strb;
    logic               w_last;
    logic               w_valid;
    logic               w_ready;

    logic               b_valid;   // response code not carried
    logic               b_ready;

    // read address
    logic [`ADDR_W-1:0] ar_addr;
    logic [7:0]         ar_len;
    logic [2:0]         ar_size;
    logic               ar_valid;
    logic               ar_ready;

    // read data
    logic [31:0]        r_data;
    logic               r_last;
    logic               r_valid;
    logic               r_ready;

    modport master (
        output aw_addr, aw_len, aw_size, aw_valid, input aw_ready,
        output w_data, w_strb, w_last, w_valid, input w_ready,
        input b_valid, output b_ready,
        output ar_addr, ar_len, ar_size, ar_valid, input ar_ready,
        input r_data, r_last, r_valid, output r_ready
    );

    modport slave (
        input aw_addr, aw_len, aw_size, aw_valid, output aw_ready,
        input w_data, w_strb, w_last, w_valid, output w_ready,
        output b_valid, input b_ready,
        input ar_addr, ar_len, ar_size, ar_valid, output ar_ready,
        output r_data, r_last, r_valid, input r_ready
    );

endinterface

//--- logic/mem_port_pkg.sv
`include "mem_port_defines.svh"

package mem_port_pkg;

    // store width seen by the write buffer
    typedef enum logic [2:0] {
        st_byte = 3'b000,
        st_half = 3'b001,
        st_word = 3'b010,
        st_line = 3'b100   // whole dirty line, drained as a burst
    } store_type_e;

    // one cache line, seen flat by the cache
    // and as beat-sized words by the bus side
    typedef union packed {
        logic [`LINE_BEATS*32-1:0]      flat;
        logic [`LINE_BEATS-1:0][31:0]   words;   // words[0] is the lowest address
    } line_u;

endpackage

//--- logic/mem_port_defines.svh
`ifndef MEM_PORT_DEFINES_SVH
`define MEM_PORT_DEFINES_SVH

// byte address width on the AXI side
`define ADDR_W 32

// 16-byte cache line
`define LINE_OFF_W 4

// 32-bit beats per line
`define LINE_BEATS 4

// AXI AxSIZE codes
`define AXI_SIZE_1 3'b000
`define AXI_SIZE_2 3'b001
`define AXI_SIZE_4 3'b010

`endif
